// ==== video_pkg.sv ====
/* shared definitions for the video path: raster defaults, counter widths,
   beam and write bus structs, write target enum */
`default_nettype none

package video_pkg;

    // raster defaults, video_top passes its own values down
    localparam int def_h_active = 32;
    localparam int def_h_total = 40;
    localparam int def_v_active = 8;
    localparam int def_v_total = 10;
    localparam int def_cen_div = 2;    // clk cycles per pixel
    localparam int def_num_layers = 2;

    localparam int h_bits = 6;     // enough for h_total up to 64
    localparam int v_bits = 4;
    localparam int pix_bits = 4;   // pixel 0 is transparent
    localparam int max_layers = 4;
    localparam int layer_bits = $clog2(max_layers);
    localparam int pal_addr_bits = layer_bits + pix_bits; // {layer, pixel}

    localparam int prog_addr_bits = 10; // bitmap row 5 bits, column 5 bits
    localparam int prog_data_bits = 8;

    // beam position plus active-high "inside active area" levels
    typedef struct packed {
        logic [h_bits-1:0] h;
        logic [v_bits-1:0] v;
        logic              lhbl; // high while h < h_active
        logic              lvbl; // high while v < v_active
    } beam_t;

    // where a single write ends up
    typedef enum logic [1:0] {
        tgt_palette,
        tgt_bitmap,
        tgt_scroll
    } prog_target_e;

    // write bus, qualified by a separate one-cycle strobe
    typedef struct packed {
        prog_target_e              target;
        logic [layer_bits-1:0]     layer;  // ignored for palette writes
        logic [prog_addr_bits-1:0] addr;
        logic [prog_data_bits-1:0] data;
    } prog_wr_t;

endpackage

`default_nettype wire

// ==== video_timing.sv ====
/* beam timing generator with the pixel enable divider, h/v beam counters
   and the active-low blanking levels */
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL = 40,
    parameter int V_ACTIVE = 8,
    parameter int V_TOTAL = 10,
    parameter int CEN_DIV = 2
) (
    input  wire                clk,
    input  wire                rst,
    output logic               pxl_cen,
    output video_pkg::beam_t   beam
);

    // divider width stays at 1 bit even when every clk is a pixel
    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam logic [CW-1:0] cen_last = CW'(CEN_DIV - 1);
    localparam logic [video_pkg::h_bits-1:0] h_last = video_pkg::h_bits'(H_TOTAL - 1);
    localparam logic [video_pkg::v_bits-1:0] v_last = video_pkg::v_bits'(V_TOTAL - 1);

    logic [CW-1:0]                div_cnt;
    logic [video_pkg::h_bits-1:0] h_cnt;
    logic [video_pkg::v_bits-1:0] v_cnt;

    // pxl_cen is registered so it stays low on the first clk after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == cen_last) ? '0 : div_cnt + 1'b1;
            pxl_cen <= (div_cnt == cen_last); // one clk in CEN_DIV
        end
    end

    // raster counters advance only on the pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pxl_cen) begin
            if (h_cnt == h_last) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1; // end of line
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // blanking levels come straight from the counters and move with h and v
    assign beam = '{
        h:    h_cnt,
        v:    v_cnt,
        lhbl: (h_cnt < H_ACTIVE),
        lvbl: (v_cnt < V_ACTIVE)
    };

    // counters never leave the raster
    a_beam_range: assert property (@(posedge clk) disable iff (rst)
        (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL));

endmodule

`default_nettype wire

// ==== tile_layer.sv ====
/* one bitmap layer: 32x32 pixel RAM, horizontal scroll register,
   write decode for its own layer id and registered pixel output */
`timescale 1ns/1ps
`default_nettype none

module tile_layer #(
    parameter int LAYER_ID = 0
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                pxl_cen,
    input  video_pkg::beam_t                   beam,
    input  video_pkg::prog_wr_t                prog,
    input  wire                                prog_we,
    output logic [video_pkg::pix_bits-1:0]     pix
);

    localparam int col_bits = 5;
    localparam int row_bits = video_pkg::prog_addr_bits - col_bits;
    localparam int ram_depth = 1 << video_pkg::prog_addr_bits;
    localparam logic [video_pkg::layer_bits-1:0] my_id = video_pkg::layer_bits'(LAYER_ID);

    logic [video_pkg::pix_bits-1:0]       ram [ram_depth];
    logic [col_bits-1:0]                  scroll;
    logic                                 bm_we;
    logic                                 scr_we;
    logic                                 own_layer;
    logic [row_bits-1:0]                  row;
    logic [col_bits-1:0]                  col;
    logic [video_pkg::prog_addr_bits-1:0] rd_addr;

    // write decode, only writes for this layer id
    assign own_layer = (prog.layer == my_id);
    assign bm_we = prog_we && own_layer && (prog.target == video_pkg::tgt_bitmap);
    assign scr_we = prog_we && own_layer && (prog.target == video_pkg::tgt_scroll);

    // pixel RAM, low nibble of the data byte
    always_ff @(posedge clk) begin
        if (bm_we) begin
            ram[prog.addr] <= prog.data[video_pkg::pix_bits-1:0];
        end
    end

    // scroll register
    always_ff @(posedge clk) begin
        if (rst) begin
            scroll <= '0;
        end else if (scr_we) begin
            scroll <= prog.data[col_bits-1:0];
        end
    end

    // v mod 32 is just v, zero extended to the row width
    assign row = row_bits'(beam.v);
    // 5-bit add wraps, giving (h + scroll) mod 32
    assign col = beam.h[col_bits-1:0] + scroll;
    assign rd_addr = {row, col};

    // registered read, one pixel behind the beam
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pix <= ram[rd_addr];
        end
    end

    // loader must keep the unused upper nibble clear on bitmap writes
    a_bitmap_data: assert property (@(posedge clk) disable iff (rst)
        bm_we |-> (prog.data[video_pkg::prog_data_bits-1:video_pkg::pix_bits] == '0));

endmodule

`default_nettype wire

// ==== pixel_delay.sv ====
/* blanking delay line plus output RGB register,
   black outside the active area */
`timescale 1ns/1ps
`default_nettype none

module pixel_delay #(
    parameter int BLANK_DLY = 3,
    parameter int DW = 12
) (
    input  wire            clk,
    input  wire            rst,
    input  wire            pxl_cen,
    input  wire            lhbl,
    input  wire            lvbl,
    input  wire  [DW-1:0]  rgb_in,
    output logic           lhbl_dly,
    output logic           lvbl_dly,
    output logic [DW-1:0]  rgb_out
);

    logic [BLANK_DLY-1:0] h_line; // blanking shift lines, index 0 is newest
    logic [BLANK_DLY-1:0] v_line;
    logic                 active;

    always_ff @(posedge clk) begin
        if (rst) begin
            h_line <= '0;
            v_line <= '0;
        end else if (pxl_cen) begin
            h_line[0] <= lhbl;
            v_line[0] <= lvbl;
            for (int i = 1; i < BLANK_DLY; i++) begin
                h_line[i] <= h_line[i-1];
                v_line[i] <= v_line[i-1];
            end
        end
    end

    // blanks at the end of the line line up with rgb_in
    assign active = h_line[BLANK_DLY-1] && v_line[BLANK_DLY-1];

    // output stage, one more pixel for both blanks and colour
    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb_out  <= '0;
        end else if (pxl_cen) begin
            lhbl_dly <= h_line[BLANK_DLY-1];
            lvbl_dly <= v_line[BLANK_DLY-1];
            rgb_out  <= active ? rgb_in : '0; // forced black in blanking
        end
    end

    a_black_in_blank: assert property (@(posedge clk) disable iff (rst)
        !(lhbl_dly && lvbl_dly) |-> (rgb_out == '0));

endmodule

`default_nettype wire

// ==== color_mixer.sv ====
/* colour mixer: layer priority choice, writable 64-entry palette,
   8-bit to 12-bit RGB expansion and blanking delay */
`timescale 1ns/1ps
`default_nettype none

module color_mixer #(
    parameter int NUM_LAYERS = 2
) (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire                                            pxl_cen,
    input  video_pkg::beam_t                               beam,
    input  wire [NUM_LAYERS-1:0][video_pkg::pix_bits-1:0]  layer_pix,
    input  wire [NUM_LAYERS-1:0]                           gfx_en,
    input  video_pkg::prog_wr_t                            prog,
    input  wire                                            prog_we,
    output logic [3:0]                                     red,
    output logic [3:0]                                     green,
    output logic [3:0]                                     blue,
    output logic                                           lhbl_dly,
    output logic                                           lvbl_dly
);

    // layer read, priority stage and palette read, one pixel each
    localparam int BLANK_DLY = 3;
    localparam int pal_depth = 1 << video_pkg::pal_addr_bits;

    logic [video_pkg::layer_bits-1:0]     sel;      // chosen layer
    logic [video_pkg::pix_bits-1:0]       sel_pix;  // its pixel
    logic [video_pkg::pal_addr_bits-1:0]  pal_addr;
    logic [video_pkg::prog_data_bits-1:0] pal [pal_depth];
    logic [video_pkg::prog_data_bits-1:0] pal_q;
    logic                                 pal_we;
    logic [11:0]                          rgb_exp;
    logic [11:0]                          rgb_out;

    // lowest enabled layer with a visible pixel wins
    always_comb begin
        sel = video_pkg::layer_bits'(NUM_LAYERS - 1);
        // nothing visible: last layer, blanked when disabled
        sel_pix = gfx_en[NUM_LAYERS-1] ? layer_pix[NUM_LAYERS-1] : '0;
        // walk down so the lowest index is assigned last
        for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
            if (gfx_en[i] && (layer_pix[i] != '0)) begin
                sel = video_pkg::layer_bits'(i);
                sel_pix = layer_pix[i];
            end
        end
    end

    // priority stage register
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_addr <= {sel, sel_pix};
        end
    end

    assign pal_we = prog_we && (prog.target == video_pkg::tgt_palette);

    // palette RAM, written any clk, read on the pixel enable
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal[prog.addr[video_pkg::pal_addr_bits-1:0]] <= prog.data;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q <= pal[pal_addr];
        end
    end

    // entry layout bbgggrrr, widened by repeating the top bits
    assign rgb_exp = {
        pal_q[2:0], pal_q[2],   // red
        pal_q[5:3], pal_q[5],   // green
        {2{pal_q[7:6]}}         // blue
    };

    pixel_delay #(
        .BLANK_DLY (BLANK_DLY),
        .DW        (12)
    ) u_delay (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (beam.lhbl),
        .lvbl     (beam.lvbl),
        .rgb_in   (rgb_exp),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb_out  (rgb_out)
    );

    assign {red, green, blue} = rgb_out;

    // registered choice must point at a layer that exists
    a_layer_index: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> (pal_addr[video_pkg::pal_addr_bits-1:video_pkg::pix_bits] < NUM_LAYERS));

endmodule

`default_nettype wire

// ==== video_top.sv ====
/* video output path top: beam timing, bitmap layers in a generate
   loop and the colour mixer */
`timescale 1ns/1ps
`default_nettype none

module video_top #(
    parameter int H_ACTIVE = video_pkg::def_h_active,
    parameter int H_TOTAL = video_pkg::def_h_total,
    parameter int V_ACTIVE = video_pkg::def_v_active,
    parameter int V_TOTAL = video_pkg::def_v_total,
    parameter int CEN_DIV = video_pkg::def_cen_div,
    parameter int NUM_LAYERS = video_pkg::def_num_layers  // up to max_layers
) (
    input  wire                        clk,
    input  wire                        rst,
    input  video_pkg::prog_wr_t        prog,
    input  wire                        prog_we,
    input  wire [NUM_LAYERS-1:0]       gfx_en,
    output logic [3:0]                 red,
    output logic [3:0]                 green,
    output logic [3:0]                 blue,
    output logic                       lhbl_dly,
    output logic                       lvbl_dly
);

    logic                                           pxl_cen;
    video_pkg::beam_t                               beam;
    logic [NUM_LAYERS-1:0][video_pkg::pix_bits-1:0] layer_pix; // one pixel per layer

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .CEN_DIV  (CEN_DIV)
    ) u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .beam    (beam)
    );

    // identical layers, each picks its own writes by id
    for (genvar k = 0; k < NUM_LAYERS; k++) begin : g_layer
        tile_layer #(
            .LAYER_ID (k)
        ) u_layer (
            .clk     (clk),
            .rst     (rst),
            .pxl_cen (pxl_cen),
            .beam    (beam),
            .prog    (prog),
            .prog_we (prog_we),
            .pix     (layer_pix[k])
        );
    end

    color_mixer #(
        .NUM_LAYERS (NUM_LAYERS)
    ) u_mixer (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .beam      (beam),
        .layer_pix (layer_pix),
        .gfx_en    (gfx_en),
        .prog      (prog),
        .prog_we   (prog_we),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly)
    );

endmodule

`default_nettype wire

// ==== video_tb.sv ====
/* testbench for video_top with LFSR stimulus, shadow memories and a reference
   model, frame checks, cycle timeout and summary */
`timescale 1ns/1ps
`default_nettype none

module video_tb;

    // own copy of the geometry
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL = 40;
    localparam int V_ACTIVE = 8;
    localparam int V_TOTAL = 10;
    localparam int CEN_DIV = 2;
    localparam int NUM_LAYERS = 2;
    localparam int half_period = 20;                            // 40 ns clk
    localparam int win_hi = (V_TOTAL - V_ACTIVE) * H_TOTAL - 16; // keep clear of next frame
    localparam int frame_clks = V_TOTAL * H_TOTAL * CEN_DIV;
    localparam int first_active_cyc = 4 * CEN_DIV + 1;          // fourth pixel enable
    localparam int frames_checked = 7;
    localparam int setup_writes = NUM_LAYERS * V_ACTIVE * 32 + 2 * 64 + NUM_LAYERS + 3;
    localparam int setup_frames = setup_writes / ((win_hi - 1) * CEN_DIV) + 8;
    // each check can wait one extra frame for alignment
    localparam int timeout_limit = (2 * frames_checked + 2) * frame_clks
                                   + setup_frames * frame_clks + 1000;

    logic                  clk;
    logic                  rst;
    video_pkg::prog_wr_t   prog;
    logic                  prog_we;
    logic [NUM_LAYERS-1:0] gfx_en;
    logic [3:0]            red;
    logic [3:0]            green;
    logic [3:0]            blue;
    logic                  lhbl_dly;
    logic                  lvbl_dly;

    // shadow state for the model
    logic [3:0] bitmap [NUM_LAYERS][1024];
    logic [7:0] palette [64];
    logic [4:0] scroll [NUM_LAYERS];
    logic [31:0] lfsr;

    int    cyc;          // clks since reset release
    int    blank_cnt;    // output pixels since lvbl_dly fell
    int    act_cnt;      // active pixels in checked frame
    int    errs;
    int    checks;
    int    tests;
    int    failed;
    bit    armed;
    bit    in_frame;
    bit    frame_done;
    bit    cmp_values;
    logic  prev_lvbl;
    string cur_test;

    video_top #(
        .H_ACTIVE   (H_ACTIVE),
        .H_TOTAL    (H_TOTAL),
        .V_ACTIVE   (V_ACTIVE),
        .V_TOTAL    (V_TOTAL),
        .CEN_DIV    (CEN_DIV),
        .NUM_LAYERS (NUM_LAYERS)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .prog     (prog),
        .prog_we  (prog_we),
        .gfx_en   (gfx_en),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // first enabled layer with a visible pixel wins or the last layer shows pixel 0
    function automatic logic [11:0] model_rgb(input int row, input int col);
        logic [3:0] px;
        logic [3:0] shown;
        logic [7:0] entry;
        int         win;
        bit         found;
        win = NUM_LAYERS - 1;
        shown = 4'h0;
        found = 0;
        for (int k = 0; k < NUM_LAYERS; k++) begin
            px = bitmap[k][row * 32 + ((col + scroll[k]) % 32)];
            if (!found && gfx_en[k] && px != 4'h0) begin
                found = 1;
                win = k;
                shown = px;
            end
        end
        entry = palette[win * 16 + shown];
        // bbgggrrr entry with the top bit repeated for red and green and blue doubled
        return {entry[2:0], entry[2], entry[5:3], entry[5], entry[7:6], entry[7:6]};
    endfunction

    // only inside the early part of the vertical blank at the output
    task automatic wait_blank_window();
        while (!((blank_cnt >= 1) && (blank_cnt < win_hi))) @(negedge clk);
    endtask

    task automatic write_mem(input video_pkg::prog_target_e tgt, input int layer,
                             input int addr, input logic [7:0] data);
        wait_blank_window();
        prog.target = tgt;
        prog.layer = video_pkg::layer_bits'(layer);
        prog.addr = video_pkg::prog_addr_bits'(addr);
        prog.data = data;
        prog_we = 1'b1;
        case (tgt)
            video_pkg::tgt_palette: palette[addr % 64] = data;
            video_pkg::tgt_bitmap:  bitmap[layer][addr] = data[3:0];
            default:                scroll[layer] = data[4:0];
        endcase
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic load_palette();
        for (int a = 0; a < 64; a++) begin
            write_mem(video_pkg::tgt_palette, 0, a, 8'(rand_bits(8)));
        end
    endtask

    task automatic set_layers(input logic [NUM_LAYERS-1:0] pattern);
        wait_blank_window();
        gfx_en = pattern;
        @(negedge clk);
    endtask

    // arm the monitor for the next whole frame, then report the test
    task automatic check_frame(input string name, input bit values);
        int e0;
        e0 = errs;
        cur_test = name;
        cmp_values = values;
        frame_done = 0;
        armed = 1;
        while (!frame_done) @(negedge clk);
        checks++;
        assert (act_cnt == H_ACTIVE * V_ACTIVE) else begin
            $display("Mismatch test=%s active pixel count expected %0d actual %0d",
                     name, H_ACTIVE * V_ACTIVE, act_cnt);
            errs++;
        end
        tests++;
        if (errs != e0) failed++;
        $display("test %s: %0d errors", name, errs - e0);
    endtask

    // one sample per output pixel with the phase counted from reset release
    always @(negedge clk) begin
        if (!rst && cyc > 1 && ((cyc - 1) % CEN_DIV) == 0) begin
            if (lvbl_dly) blank_cnt = 0;
            else blank_cnt++;
            if (lvbl_dly && !prev_lvbl && armed) begin  // frame start
                in_frame = 1;
                armed = 0;
                act_cnt = 0;
            end
            if (lhbl_dly && lvbl_dly) begin
                if (in_frame && cmp_values) begin
                    checks++;
                    assert ({red, green, blue} === model_rgb(act_cnt / H_ACTIVE,
                                                             act_cnt % H_ACTIVE)) else begin
                        $display("Mismatch test=%s v=%0d h=%0d expected %h actual %h",
                                 cur_test, act_cnt / H_ACTIVE, act_cnt % H_ACTIVE,
                                 model_rgb(act_cnt / H_ACTIVE, act_cnt % H_ACTIVE),
                                 {red, green, blue});
                        errs++;
                    end
                end
                if (in_frame) act_cnt++;
            end else begin
                checks++;
                assert ({red, green, blue} === 12'h000) else begin
                    $display("Mismatch test=%s blanked pixel expected %h actual %h",
                             cur_test, 12'h000, {red, green, blue});
                    errs++;
                end
            end
            if (in_frame && !lvbl_dly) begin   // frame end
                in_frame = 0;
                frame_done = 1;
            end
            prev_lvbl = lvbl_dly;
        end
    end

    always @(posedge clk) begin
        if (!rst) cyc <= cyc + 1;
        if (cyc >= timeout_limit) begin
            $display("timeout: no result after %0d clock cycles", cyc);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        prog = '0;
        prog_we = 1'b0;
        gfx_en = '1;
        lfsr = 32'h6eb23683;
        cyc = 0;
        blank_cnt = 1 << 20;   // no writes before the first real vblank
        act_cnt = 0;
        errs = 0;
        checks = 0;
        tests = 0;
        failed = 0;
        armed = 0;
        in_frame = 0;
        frame_done = 0;
        cmp_values = 0;
        prev_lvbl = 1'b0;
        cur_test = "reset";
        for (int k = 0; k < NUM_LAYERS; k++) scroll[k] = 5'd0;

        // outputs quiet during reset and until the first active pixel
        repeat (3) begin
            @(negedge clk);
            checks++;
            assert (!lhbl_dly && !lvbl_dly && {red, green, blue} == 12'h000) else begin
                $display("Mismatch test=reset outputs expected 00/%h actual %b%b/%h",
                         12'h000, lhbl_dly, lvbl_dly, {red, green, blue});
                errs++;
            end
        end
        rst = 1'b0;
        while (!(lhbl_dly && lvbl_dly)) begin
            checks++;
            assert (!lhbl_dly && !lvbl_dly && {red, green, blue} === 12'h000) else begin
                $display("Mismatch test=reset outputs expected 00/%h actual %b%b/%h",
                         12'h000, lhbl_dly, lvbl_dly, {red, green, blue});
                errs++;
            end
            @(negedge clk);
        end
        // beam (0,0) reaches the output after four pixel enables
        checks++;
        assert (cyc == first_active_cyc) else begin
            $display("Mismatch test=reset first active pixel cycle expected %0d actual %0d",
                     first_active_cyc, cyc);
            errs++;
        end
        check_frame("reset_and_count", 0);   // bitmaps still unloaded

        // rows beyond V_ACTIVE never reach the screen
        for (int k = 0; k < NUM_LAYERS; k++)
            for (int a = 0; a < V_ACTIVE * 32; a++)
                write_mem(video_pkg::tgt_bitmap, k, a, {4'h0, 4'(rand_bits(4))});
        load_palette();
        check_frame("random_bitmap_palette", 1);

        for (int k = 0; k < NUM_LAYERS; k++)
            write_mem(video_pkg::tgt_scroll, k, 0, {3'b000, 5'(rand_bits(5))});
        check_frame("scroll", 1);

        set_layers(2'b10);
        check_frame("layer0_off", 1);
        set_layers(2'b01);
        check_frame("layer1_off", 1);
        set_layers(2'b00);
        check_frame("both_off", 1);
        set_layers(2'b11);

        load_palette();
        check_frame("palette_rewrite", 1);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errs);
        if (errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
video_pkg.sv
video_timing.sv
tile_layer.sv
pixel_delay.sv
color_mixer.sv
video_top.sv
video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the video path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module video_tb \
    --Mdir obj_dir \
    -o video_tb_sim

./obj_dir/video_tb_sim | tee sim.log

# pass only when the testbench printed its pass line
if grep -q "^Simulation completed successfully$" sim.log; then
    exit 0
else
    exit 1
fi
